// ==== hdl/decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module decoder import rv64_pkg::*; (
    input  wire logic [inst_w-1:0]      inst,
    output logic      [reg_index_w-1:0] rs1_index,
    output logic      [reg_index_w-1:0] rs2_index,
    output logic      [reg_index_w-1:0] rd_index,
    output logic                        rd_en,
    output logic                        mem_read,
    output logic                        mem_write,
    output wb_sel_e                     wb_sel,
    output logic                        is_branch,
    output logic                        is_jal,
    output logic                        is_trap,
    exec_ctrl_if.decoder_mp             ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{52{inst[31]}}, inst[31:20]};
    assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        rs1_index          = inst[19:15];
        rs2_index          = inst[24:20];
        rd_index           = inst[11:7];
        rd_en              = 1'b0;
        mem_read           = 1'b0;
        mem_write          = 1'b0;
        wb_sel             = wb_alu;
        is_branch          = 1'b0;
        is_jal             = 1'b0;
        is_trap            = 1'b0;
        ctrl.alu_op        = alu_add;
        ctrl.alu_src_pc    = 1'b0;
        ctrl.alu_src_imm   = 1'b0;
        ctrl.comp_type     = comp_eq;
        ctrl.shift_imm_sel = 1'b0;
        ctrl.imm           = '0;

        case (opcode)
            op_imm: begin
                ctrl.imm         = imm_i;
                ctrl.alu_src_imm = 1'b1;
                case (funct3)
                    3'b000: begin
                        rd_en = 1'b1;
                    end
                    3'b001: begin
                        // 6-bit shamt, funct6 in inst[31:26]
                        ctrl.alu_op        = alu_sll;
                        ctrl.shift_imm_sel = 1'b1;
                        rd_en              = (inst[31:26] == 6'b000000);
                    end
                    3'b101: begin
                        ctrl.alu_op        = inst[30] ? alu_sra : alu_srl;
                        ctrl.shift_imm_sel = 1'b1;
                        rd_en              = (inst[31] == 1'b0) && (inst[29:26] == 4'b0000);
                    end
                    default: ;
                endcase
            end
            op_reg: begin
                rd_en = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = alu_add;
                    {7'h20, 3'b000}: ctrl.alu_op = alu_sub;
                    {7'h00, 3'b001}: ctrl.alu_op = alu_sll;
                    {7'h00, 3'b010}: ctrl.alu_op = alu_slt;
                    {7'h00, 3'b011}: ctrl.alu_op = alu_sltu;
                    {7'h00, 3'b100}: ctrl.alu_op = alu_xor;
                    {7'h00, 3'b101}: ctrl.alu_op = alu_srl;
                    {7'h20, 3'b101}: ctrl.alu_op = alu_sra;
                    {7'h00, 3'b110}: ctrl.alu_op = alu_or;
                    {7'h00, 3'b111}: ctrl.alu_op = alu_and;
                    default:         rd_en       = 1'b0;
                endcase
            end
            op_lui: begin
                ctrl.imm = imm_u;
                wb_sel   = wb_imm;
                rd_en    = 1'b1;
            end
            op_load: begin
                // ld only
                ctrl.imm         = imm_i;
                ctrl.alu_src_imm = 1'b1;
                wb_sel           = wb_load;
                mem_read         = (funct3 == 3'b011);
                rd_en            = (funct3 == 3'b011);
            end
            op_store: begin
                ctrl.imm         = imm_s;
                ctrl.alu_src_imm = 1'b1;
                mem_write        = (funct3 == 3'b011);
            end
            op_branch: begin
                // alu forms the target, comparator decides
                ctrl.imm         = imm_b;
                ctrl.alu_src_pc  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                is_branch        = 1'b1;
                case (funct3)
                    3'b000:  ctrl.comp_type = comp_eq;
                    3'b001:  ctrl.comp_type = comp_ne;
                    3'b100:  ctrl.comp_type = comp_lt;
                    3'b101:  ctrl.comp_type = comp_ge;
                    default: is_branch      = 1'b0;
                endcase
            end
            op_jal: begin
                ctrl.imm         = imm_j;
                ctrl.alu_src_pc  = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                is_jal           = 1'b1;
                wb_sel           = wb_link;
                rd_en            = 1'b1;
            end
            op_trap: begin
                // read a0 so the top can latch the exit code
                is_trap   = 1'b1;
                rs1_index = 5'd10;
            end
            default: ;
        endcase

        if (rd_index == '0) begin
            rd_en = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exec_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface exec_ctrl_if import rv64_pkg::*; ();

    alu_op_e         alu_op;
    logic            alu_src_pc;
    logic            alu_src_imm;
    comp_type_e      comp_type;
    // shift amount from the immediate instead of rs2
    logic            shift_imm_sel;
    logic [xlen-1:0] imm;

    modport decoder_mp (
        output alu_op,
        output alu_src_pc,
        output alu_src_imm,
        output comp_type,
        output shift_imm_sel,
        output imm
    );

    modport execute_mp (
        input alu_op,
        input alu_src_pc,
        input alu_src_imm,
        input comp_type,
        input shift_imm_sel,
        input imm
    );

endinterface

`default_nettype wire

// ==== hdl/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module execute_unit import rv64_pkg::*; (
    exec_ctrl_if.execute_mp      ctrl,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] rs1_data,
    input  wire logic [xlen-1:0] rs2_data,
    output logic      [xlen-1:0] alu_res,
    output logic                 branch_taken
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [5:0]      shamt;
    logic            rs_eq;
    logic            rs_lt;

    assign op_a  = ctrl.alu_src_pc ? pc : rs1_data;
    assign op_b  = ctrl.alu_src_imm ? ctrl.imm : rs2_data;
    assign shamt = ctrl.shift_imm_sel ? ctrl.imm[5:0] : rs2_data[5:0];

    always_comb begin
        case (ctrl.alu_op)
            alu_add: begin
                alu_res = op_a + op_b;
            end
            alu_sub: begin
                alu_res = op_a - op_b;
            end
            alu_and: begin
                alu_res = op_a & op_b;
            end
            alu_or: begin
                alu_res = op_a | op_b;
            end
            alu_xor: begin
                alu_res = op_a ^ op_b;
            end
            alu_slt: begin
                alu_res = {63'd0, $signed(op_a) < $signed(op_b)};
            end
            alu_sltu: begin
                alu_res = {63'd0, op_a < op_b};
            end
            alu_sll: begin
                alu_res = op_a << shamt;
            end
            alu_srl: begin
                alu_res = op_a >> shamt;
            end
            alu_sra: begin
                alu_res = $unsigned($signed(op_a) >>> shamt);
            end
            default: begin
                alu_res = op_a + op_b;
            end
        endcase
    end

    // branch compare always on the register operands
    assign rs_eq = (rs1_data == rs2_data);
    assign rs_lt = ($signed(rs1_data) < $signed(rs2_data));

    always_comb begin
        case (ctrl.comp_type)
            comp_eq: branch_taken = rs_eq;
            comp_ne: branch_taken = !rs_eq;
            comp_lt: branch_taken = rs_lt;
            comp_ge: branch_taken = !rs_lt;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_unit import rv64_pkg::*; (
    input  wire logic            clock,
    input  wire logic            reset,
    input  wire logic            halt,
    input  wire logic            is_branch,
    input  wire logic            branch_taken,
    input  wire logic            is_jal,
    input  wire logic [xlen-1:0] target,
    output logic      [xlen-1:0] pc
);

    logic            redirect;
    logic [xlen-1:0] pc_next;

    assign redirect = is_jal | (is_branch & branch_taken);

    always_comb begin
        if (halt) begin
            pc_next = pc;
        end else if (redirect) begin
            pc_next = target;
        end else begin
            pc_next = pc + 64'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= pc_start;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regfile import rv64_pkg::*; (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   rd_en,
    input  wire logic [reg_index_w-1:0] rd_index,
    input  wire logic [xlen-1:0]        rd_data,
    input  wire logic [reg_index_w-1:0] rs1_index,
    input  wire logic [reg_index_w-1:0] rs2_index,
    output logic      [xlen-1:0]        rs1_data,
    output logic      [xlen-1:0]        rs2_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_en && (rd_index != '0)) begin
            regs[rd_index] <= rd_data;
        end
    end

    // x0 reads as zero regardless of contents
    assign rs1_data = (rs1_index == '0) ? '0 : regs[rs1_index];
    assign rs2_data = (rs2_index == '0) ? '0 : regs[rs2_index];

endmodule

`default_nettype wire

// ==== hdl/rv64_pkg.sv ====
`default_nettype none

package rv64_pkg;

    localparam int xlen        = 64;
    localparam int reg_index_w = 5;
    localparam int inst_w      = 32;

    // 512 doublewords, 4 KiB
    localparam int ram_depth_words = 512;
    localparam int ram_addr_w      = $clog2(ram_depth_words);

    localparam logic [xlen-1:0] pc_start = 64'h0;

    localparam logic [6:0] op_imm    = 7'h13;
    localparam logic [6:0] op_reg    = 7'h33;
    localparam logic [6:0] op_lui    = 7'h37;
    localparam logic [6:0] op_load   = 7'h03;
    localparam logic [6:0] op_store  = 7'h23;
    localparam logic [6:0] op_branch = 7'h63;
    localparam logic [6:0] op_jal    = 7'h6f;
    // custom opcode ending the program
    localparam logic [6:0] op_trap   = 7'h6b;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_op_e;

    typedef enum logic [1:0] {
        comp_eq,
        comp_ne,
        comp_lt,
        comp_ge
    } comp_type_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_load,
        wb_imm,
        wb_link
    } wb_sel_e;

endpackage

`default_nettype wire

// ==== hdl/sim_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module sim_top import rv64_pkg::*; (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   prog_we,
    input  wire logic [ram_addr_w:0]    prog_addr,
    input  wire logic [inst_w-1:0]      prog_data,
    output logic                        commit_valid,
    output logic                        commit_wen,
    output logic      [xlen-1:0]        commit_pc,
    output logic      [inst_w-1:0]      commit_inst,
    output logic      [reg_index_w-1:0] commit_wdest,
    output logic      [xlen-1:0]        commit_wdata,
    output logic      [31:0]            instr_count,
    output logic                        trap,
    output logic      [7:0]             trap_code
);

    logic [xlen-1:0]        pc;
    logic [inst_w-1:0]      inst;
    logic [reg_index_w-1:0] rs1_index;
    logic [reg_index_w-1:0] rs2_index;
    logic [reg_index_w-1:0] rd_index;
    logic                   rd_en;
    logic                   mem_read;
    logic                   mem_write;
    wb_sel_e                wb_sel;
    logic                   is_branch;
    logic                   is_jal;
    logic                   is_trap;
    logic [xlen-1:0]        alu_res;
    logic                   branch_taken;
    logic [xlen-1:0]        rs1_data;
    logic [xlen-1:0]        rs2_data;
    logic [xlen-1:0]        read_data;
    logic [xlen-1:0]        rd_data;
    logic                   halted;
    logic                   retire;
    logic                   rd_en_live;
    logic                   mem_write_live;

    exec_ctrl_if ctrl_if ();

    // no architectural effects once the trap has retired
    assign retire         = !halted && !is_trap;
    assign rd_en_live     = rd_en && !halted;
    assign mem_write_live = mem_write && !halted && !reset;
    assign trap           = halted;

    always_comb begin
        case (wb_sel)
            wb_load: rd_data = read_data;
            wb_imm:  rd_data = ctrl_if.imm;
            wb_link: rd_data = pc + 64'd4;
            default: rd_data = alu_res;
        endcase
    end

    fetch_unit u_fetch (
        .clock        (clock),
        .reset        (reset),
        .halt         (halted | is_trap),
        .is_branch    (is_branch),
        .branch_taken (branch_taken),
        .is_jal       (is_jal),
        .target       (alu_res),
        .pc           (pc)
    );

    decoder u_decoder (
        .inst      (inst),
        .rs1_index (rs1_index),
        .rs2_index (rs2_index),
        .rd_index  (rd_index),
        .rd_en     (rd_en),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .wb_sel    (wb_sel),
        .is_branch (is_branch),
        .is_jal    (is_jal),
        .is_trap   (is_trap),
        .ctrl      (ctrl_if.decoder_mp)
    );

    execute_unit u_execute (
        .ctrl         (ctrl_if.execute_mp),
        .pc           (pc),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .alu_res      (alu_res),
        .branch_taken (branch_taken)
    );

    regfile u_regfile (
        .clock     (clock),
        .reset     (reset),
        .rd_en     (rd_en_live),
        .rd_index  (rd_index),
        .rd_data   (rd_data),
        .rs1_index (rs1_index),
        .rs2_index (rs2_index),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    unified_ram u_ram (
        .clock      (clock),
        .prog_we    (prog_we & reset),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pc         (pc),
        .mem_read   (mem_read),
        .mem_write  (mem_write_live),
        .data_addr  (alu_res),
        .write_data (rs2_data),
        .inst       (inst),
        .read_data  (read_data)
    );

    // commit observer, describes the instruction retired on this edge
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
            commit_pc    <= '0;
            commit_inst  <= '0;
            commit_wdest <= '0;
            commit_wdata <= '0;
            instr_count  <= '0;
            halted       <= 1'b0;
            trap_code    <= '0;
        end else if (!halted) begin
            commit_valid <= retire;
            commit_wen   <= rd_en_live;
            commit_pc    <= pc;
            commit_inst  <= inst;
            commit_wdest <= rd_index;
            commit_wdata <= rd_data;
            instr_count  <= instr_count + {31'd0, retire};
            if (is_trap) begin
                // rs1 is steered to a0 by the decoder
                halted    <= 1'b1;
                trap_code <= rs1_data[7:0];
            end
        end else begin
            commit_valid <= 1'b0;
            commit_wen   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/unified_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module unified_ram import rv64_pkg::*; (
    input  wire logic                  clock,
    input  wire logic                  prog_we,
    input  wire logic [ram_addr_w:0]   prog_addr,
    input  wire logic [inst_w-1:0]     prog_data,
    input  wire logic [xlen-1:0]       pc,
    input  wire logic                  mem_read,
    input  wire logic                  mem_write,
    input  wire logic [xlen-1:0]       data_addr,
    input  wire logic [xlen-1:0]       write_data,
    output logic      [inst_w-1:0]     inst,
    output logic      [xlen-1:0]       read_data
);

    logic [xlen-1:0]       mem [ram_depth_words];
    logic [ram_addr_w-1:0] fetch_idx;
    logic [ram_addr_w-1:0] data_idx;
    logic [ram_addr_w-1:0] prog_idx;
    logic [xlen-1:0]       fetch_word;

    assign fetch_idx = pc[ram_addr_w+2:3];
    assign data_idx  = data_addr[ram_addr_w+2:3];
    assign prog_idx  = prog_addr[ram_addr_w:1];

    // preload takes priority over the data port
    always_ff @(posedge clock) begin
        if (prog_we) begin
            if (prog_addr[0]) begin
                mem[prog_idx][63:32] <= prog_data;
            end else begin
                mem[prog_idx][31:0] <= prog_data;
            end
        end else if (mem_write) begin
            mem[data_idx] <= write_data;
        end
    end

    // pc[2] picks the half of the doubleword
    assign fetch_word = mem[fetch_idx];
    assign inst       = pc[2] ? fetch_word[63:32] : fetch_word[31:0];

    assign read_data = mem_read ? mem[data_idx] : '0;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/10ps --top-module tb_sim_top \
        -f rv64_core.f -o tb_sim_top \
    && ./obj_dir/tb_sim_top | tee /dev/stderr | grep -qx "sim passed" \
    && echo "simulation OK" \
    || { echo "simulation FAILED"; exit 1; }

// ==== rv64_core.f ====
hdl/rv64_pkg.sv
hdl/exec_ctrl_if.sv
hdl/decoder.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/regfile.sv
hdl/unified_ram.sv
hdl/sim_top.sv
verification/tb_sim_top.sv

// ==== verification/tb_sim_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_sim_top import rv64_pkg::*; ();

    localparam logic [31:0] trap_inst = {25'd0, op_trap};

    logic        clock;
    logic        reset;
    logic        prog_we;
    logic [9:0]  prog_addr;
    logic [31:0] prog_data;
    logic        commit_valid;
    logic        commit_wen;
    logic [63:0] commit_pc;
    logic [31:0] commit_inst;
    logic [4:0]  commit_wdest;
    logic [63:0] commit_wdata;
    logic [31:0] instr_count;
    logic        trap;
    logic [7:0]  trap_code;

    logic [31:0] prog [$];
    logic [9:0]  image_addr [$];
    logic [31:0] image_data [$];
    int          budget_cycles = 0;
    int          elapsed_cycles = 0;

    sim_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .commit_valid (commit_valid),
        .commit_wen   (commit_wen),
        .commit_pc    (commit_pc),
        .commit_inst  (commit_inst),
        .commit_wdest (commit_wdest),
        .commit_wdata (commit_wdata),
        .instr_count  (instr_count),
        .trap         (trap),
        .trap_code    (trap_code)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] store_dw(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] branch(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] lui_inst(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    function automatic logic [31:0] jal_inst(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic logic [63:0] sign_extend12(input logic [11:0] value);
        return {{52{value[11]}}, value};
    endfunction

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // data doubleword placed next to the program
    task automatic poke_data(input logic [11:0] byte_addr, input logic [63:0] value);
        image_addr.push_back(byte_addr[11:2]);
        image_data.push_back(value[31:0]);
        image_addr.push_back(byte_addr[11:2] + 10'd1);
        image_data.push_back(value[63:32]);
    endtask

    task automatic load_program(input int extra_cycles);
        budget_cycles += prog.size() + image_addr.size() + 4 + prog.size() + extra_cycles;
        @(negedge clock);
        reset = 1'b1;
        foreach (prog[i]) begin
            @(negedge clock);
            prog_we   = 1'b1;
            prog_addr = 10'(i);
            prog_data = prog[i];
        end
        foreach (image_addr[i]) begin
            @(negedge clock);
            prog_we   = 1'b1;
            prog_addr = image_addr[i];
            prog_data = image_data[i];
        end
        @(negedge clock);
        prog_we = 1'b0;
        repeat (2) @(negedge clock);
        check("commit_valid", 64'(commit_valid), 64'd0);
        check("commit_wen", 64'(commit_wen), 64'd0);
        check("trap", 64'(trap), 64'd0);
        check("instr_count", 64'(instr_count), 64'd0);
        reset = 1'b0;
        image_addr.delete();
        image_data.delete();
    endtask

    task automatic expect_commit(input logic [63:0] pc, input logic wen,
                                 input logic [4:0] rd, input logic [63:0] value);
        do begin
            @(negedge clock);
        end while (commit_valid !== 1'b1);
        check("commit_pc", commit_pc, pc);
        check("commit_inst", 64'(commit_inst), 64'(prog[pc[11:2]]));
        check("commit_wen", 64'(commit_wen), 64'(wen));
        if (wen) begin
            check("commit_wdest", 64'(commit_wdest), 64'(rd));
            check("commit_wdata", commit_wdata, value);
        end
    endtask

    task automatic wait_trap();
        do begin
            @(negedge clock);
        end while (trap !== 1'b1);
    endtask

    task automatic arith_logic_test();
        logic [11:0] a;
        logic [11:0] b;
        logic [63:0] va;
        logic [63:0] vb;
        a  = 12'($urandom());
        b  = 12'($urandom());
        va = sign_extend12(a);
        vb = sign_extend12(b);
        prog.delete();
        prog.push_back(i_type(a, 5'd0, 3'b000, 5'd1, op_imm));
        prog.push_back(i_type(b, 5'd0, 3'b000, 5'd2, op_imm));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        prog.push_back(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd5));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd7));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd8));
        prog.push_back(r_type(7'h00, 5'd2, 5'd1, 3'b011, 5'd9));
        prog.push_back(trap_inst);
        load_program(4);
        expect_commit(64'd0, 1'b1, 5'd1, va);
        expect_commit(64'd4, 1'b1, 5'd2, vb);
        expect_commit(64'd8, 1'b1, 5'd3, va + vb);
        expect_commit(64'd12, 1'b1, 5'd4, va - vb);
        expect_commit(64'd16, 1'b1, 5'd5, va & vb);
        expect_commit(64'd20, 1'b1, 5'd6, va | vb);
        expect_commit(64'd24, 1'b1, 5'd7, va ^ vb);
        expect_commit(64'd28, 1'b1, 5'd8, 64'($signed(va) < $signed(vb)));
        expect_commit(64'd32, 1'b1, 5'd9, 64'(va < vb));
    endtask

    task automatic shift_lui_test();
        logic [19:0] u;
        logic [5:0]  sh_i;
        logic [5:0]  sh_r;
        logic [63:0] v;
        logic [63:0] sra_i;
        logic [63:0] sra_r;
        // upper bit forced so the value is negative
        u     = 20'($urandom()) | 20'h80000;
        sh_i  = 6'($urandom()) | 6'd1;
        sh_r  = 6'($urandom()) | 6'd1;
        v     = {{32{u[19]}}, u, 12'h000};
        sra_i = $signed(v) >>> sh_i;
        sra_r = $signed(v) >>> sh_r;
        prog.delete();
        prog.push_back(lui_inst(u, 5'd1));
        prog.push_back(i_type({6'b000000, sh_i}, 5'd1, 3'b001, 5'd2, op_imm));
        prog.push_back(i_type({6'b000000, sh_i}, 5'd1, 3'b101, 5'd3, op_imm));
        prog.push_back(i_type({6'b010000, sh_i}, 5'd1, 3'b101, 5'd4, op_imm));
        prog.push_back(i_type({6'd0, sh_r}, 5'd0, 3'b000, 5'd5, op_imm));
        prog.push_back(r_type(7'h00, 5'd5, 5'd1, 3'b001, 5'd6));
        prog.push_back(r_type(7'h00, 5'd5, 5'd1, 3'b101, 5'd7));
        prog.push_back(r_type(7'h20, 5'd5, 5'd1, 3'b101, 5'd8));
        prog.push_back(trap_inst);
        load_program(4);
        expect_commit(64'd0, 1'b1, 5'd1, v);
        expect_commit(64'd4, 1'b1, 5'd2, v << sh_i);
        expect_commit(64'd8, 1'b1, 5'd3, v >> sh_i);
        expect_commit(64'd12, 1'b1, 5'd4, sra_i);
        expect_commit(64'd16, 1'b1, 5'd5, 64'(sh_r));
        expect_commit(64'd20, 1'b1, 5'd6, v << sh_r);
        expect_commit(64'd24, 1'b1, 5'd7, v >> sh_r);
        expect_commit(64'd28, 1'b1, 5'd8, sra_r);
    endtask

    task automatic memory_test();
        logic [63:0] value;
        logic [63:0] junk;
        value = {$urandom(), $urandom()};
        junk  = {$urandom(), $urandom()} | 64'h1;
        prog.delete();
        poke_data(12'h100, value);
        poke_data(12'h188, junk);
        prog.push_back(i_type(12'h100, 5'd0, 3'b011, 5'd1, op_load));
        prog.push_back(store_dw(12'h180, 5'd1, 5'd0));
        prog.push_back(i_type(12'h180, 5'd0, 3'b011, 5'd2, op_load));
        prog.push_back(i_type(12'h7ff, 5'd1, 3'b000, 5'd0, op_imm));
        prog.push_back(r_type(7'h00, 5'd0, 5'd0, 3'b110, 5'd5));
        prog.push_back(store_dw(12'h188, 5'd0, 5'd0));
        prog.push_back(i_type(12'h188, 5'd0, 3'b011, 5'd4, op_load));
        prog.push_back(trap_inst);
        load_program(4);
        expect_commit(64'd0, 1'b1, 5'd1, value);
        expect_commit(64'd4, 1'b0, 5'd0, 64'd0);
        expect_commit(64'd8, 1'b1, 5'd2, value);
        expect_commit(64'd12, 1'b0, 5'd0, 64'd0);
        expect_commit(64'd16, 1'b1, 5'd5, 64'd0);
        expect_commit(64'd20, 1'b0, 5'd0, 64'd0);
        expect_commit(64'd24, 1'b1, 5'd4, 64'd0);
    endtask

    task automatic control_flow_test();
        logic [11:0] n;
        n = 12'(3 + $urandom() % 6);
        prog.delete();
        prog.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd1, op_imm));
        prog.push_back(i_type(12'd5, 5'd0, 3'b000, 5'd2, op_imm));
        prog.push_back(branch(13'd8, 5'd2, 5'd1, 3'b000));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd3, op_imm));
        prog.push_back(branch(13'd8, 5'd2, 5'd1, 3'b001));
        prog.push_back(i_type(12'd0, 5'd0, 3'b000, 5'd4, op_imm));
        prog.push_back(i_type(n, 5'd0, 3'b000, 5'd5, op_imm));
        // loop body at 28 and blt back by 4
        prog.push_back(i_type(12'd1, 5'd4, 3'b000, 5'd4, op_imm));
        prog.push_back(branch(13'h1ffc, 5'd5, 5'd4, 3'b100));
        prog.push_back(branch(13'd8, 5'd5, 5'd4, 3'b101));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd6, op_imm));
        prog.push_back(jal_inst(21'd12, 5'd7));
        prog.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd6, op_imm));
        prog.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd6, op_imm));
        prog.push_back(i_type(12'd3, 5'd0, 3'b000, 5'd8, op_imm));
        prog.push_back(trap_inst);
        load_program(2 * int'(n) + 4);
        expect_commit(64'd0, 1'b1, 5'd1, 64'd5);
        expect_commit(64'd4, 1'b1, 5'd2, 64'd5);
        expect_commit(64'd8, 1'b0, 5'd0, 64'd0);
        expect_commit(64'd16, 1'b0, 5'd0, 64'd0);
        expect_commit(64'd20, 1'b1, 5'd4, 64'd0);
        expect_commit(64'd24, 1'b1, 5'd5, 64'(n));
        for (int k = 1; k <= int'(n); k++) begin
            expect_commit(64'd28, 1'b1, 5'd4, 64'(k));
            expect_commit(64'd32, 1'b0, 5'd0, 64'd0);
        end
        expect_commit(64'd36, 1'b0, 5'd0, 64'd0);
        expect_commit(64'd44, 1'b1, 5'd7, 64'd48);
        expect_commit(64'd56, 1'b1, 5'd8, 64'd3);
        wait_trap();
        check("instr_count", 64'(instr_count), 64'(9 + 2 * int'(n)));
    endtask

    task automatic trap_test();
        logic [7:0] code;
        code = 8'($urandom());
        prog.delete();
        prog.push_back(i_type({4'd0, code}, 5'd0, 3'b000, 5'd10, op_imm));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd11, op_imm));
        prog.push_back(trap_inst);
        load_program(20);
        expect_commit(64'd0, 1'b1, 5'd10, 64'(code));
        expect_commit(64'd4, 1'b1, 5'd11, 64'd1);
        wait_trap();
        check("trap_code", 64'(trap_code), 64'(code));
        check("instr_count", 64'(instr_count), 64'd2);
        repeat (10) begin
            @(negedge clock);
            check("commit_valid", 64'(commit_valid), 64'd0);
            check("trap", 64'(trap), 64'd1);
        end
        reset = 1'b1;
        repeat (2) @(negedge clock);
        check("trap", 64'(trap), 64'd0);
        check("instr_count", 64'(instr_count), 64'd0);
        reset = 1'b0;
    endtask

    initial begin : watchdog
        do begin
            @(posedge clock);
            elapsed_cycles++;
        end while (elapsed_cycles <= 2 * budget_cycles);
        $display("timeout: the DUT stopped making progress after %0d cycles", elapsed_cycles);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(88));
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        arith_logic_test();
        shift_lui_test();
        memory_test();
        control_flow_test();
        trap_test();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
